/* build.f */
logic/rs5_pkg.sv
logic/stage_if.sv
logic/credit_fifo.sv
logic/mem_stage.sv
logic/data_memory.sv
logic/retire.sv
logic/regbank.sv
logic/retire_backend.sv
tests/tb_retire_backend.sv

/* logic/credit_fifo.sv */
// Credit FIFO that queues incoming operations and hands back one credit per slot it frees
`default_nettype none
`timescale 1ns/100ps

module credit_fifo (
    input  logic          clk,
    input  logic          arst_n_i,
    input  logic          op_valid_i,   // Sender spends one credit on each pulse
    input  rs5_pkg::op_t  op_i,
    output logic          credit_o,     // One pulse per popped entry
    stage_if.source       deq
);

    rs5_pkg::op_t                        slots [rs5_pkg::FIFO_DEPTH];  // Circular storage
    logic [rs5_pkg::FIFO_PTR_W-1:0]      wr_ptr;
    logic [rs5_pkg::FIFO_PTR_W-1:0]      rd_ptr;
    logic [rs5_pkg::FIFO_CNT_W-1:0]      count;                          // Entries held
    logic                                push;
    logic                                pop;

    assign push     = op_valid_i;
    assign pop      = (count != '0);   // Head leaves at every edge while the queue holds data
    assign credit_o = pop;             // The freed slot goes back to the sender at the same edge

    // Payload slots are written on push and carry no reset
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= op_i;
        end
    end

    // Pointers, occupancy and the registered head toward the memory stage
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            deq.valid <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at FIFO_DEPTH, a power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // Both or neither leave occupancy unchanged
            endcase
            deq.valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            deq.op <= slots[rd_ptr];   // Head is held only while valid, so no reset needed here
        end
    end

    // A sender that respects its credits can never find the queue full
    assert property (@(posedge clk) disable iff (!arst_n_i)
        op_valid_i |-> (count != rs5_pkg::FIFO_CNT_W'(rs5_pkg::FIFO_DEPTH)));

endmodule

`default_nettype wire

/* logic/data_memory.sv */
// Data RAM with byte-lane write enables and a registered read one cycle after the address
`default_nettype none
`timescale 1ns/100ps

module data_memory (
    input  logic                             clk,
    input  logic [rs5_pkg::DMEM_ADDR_W-1:0]  addr_i,
    input  logic [3:0]                       be_i,
    input  logic [31:0]                      wdata_i,
    output logic [31:0]                      rdata_o
);

    logic [rs5_pkg::XLEN-1:0] ram [rs5_pkg::DMEM_WORDS];   // Word-organised storage

    // Each enabled lane takes its byte from the write data
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (be_i[lane]) begin
                ram[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
            end
        end
    end

    // Read returns the word as it was before a write at the same edge
    always_ff @(posedge clk) begin
        rdata_o <= ram[addr_i];
    end

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
// Memory stage that turns stores into byte-lane writes, starts loads and forwards ops to retire
`default_nettype none
`timescale 1ns/100ps

module mem_stage (
    input  logic                             clk,
    input  logic                             arst_n_i,
    stage_if.sink                            enq,
    stage_if.source                          ret,
    output logic [rs5_pkg::DMEM_ADDR_W-1:0]  dmem_addr_o,
    output logic [3:0]                       dmem_be_o,
    output logic [31:0]                      dmem_wdata_o
);

    logic [1:0] offset;   // Byte position inside the addressed word

    assign offset      = enq.op.result[1:0];
    assign dmem_addr_o = enq.op.result[rs5_pkg::DMEM_ADDR_W+1:2];   // Word address

    // Lanes are picked by the low address bits and the data is copied into every lane
    always_comb begin
        dmem_be_o    = 4'b0000;   // Loads and ALU operations never write
        dmem_wdata_o = enq.op.store_data;
        unique case (enq.op.operation)
            rs5_pkg::SB: begin
                dmem_be_o    = 4'b0001 << offset;
                dmem_wdata_o = {4{enq.op.store_data[7:0]}};
            end
            rs5_pkg::SH: begin
                dmem_be_o    = offset[1] ? 4'b1100 : 4'b0011;
                dmem_wdata_o = {2{enq.op.store_data[15:0]}};
            end
            rs5_pkg::SW: dmem_be_o = 4'b1111;
            default:     dmem_be_o = 4'b0000;
        endcase
        if (!enq.valid) begin
            dmem_be_o = 4'b0000;   // Idle cycles leave memory untouched
        end
    end

    // The operation reaches retire in the cycle its read data comes back
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ret.valid <= 1'b0;
        end else begin
            ret.valid <= enq.valid;
        end
    end

    always_ff @(posedge clk) begin
        ret.op <= enq.op;   // Payload follows valid without its own reset
    end

    // Halfword stores must sit on a halfword boundary, there is no misalignment trap
    assert property (@(posedge clk) disable iff (!arst_n_i)
        (enq.valid && enq.op.operation == rs5_pkg::SH) |-> !enq.op.result[0]);

endmodule

`default_nettype wire

/* logic/regbank.sv */
// Register bank of 32 words with x0 tied to zero and a combinational debug read port
`default_nettype none
`timescale 1ns/100ps

module regbank (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            we_i,
    input  logic [rs5_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  logic [31:0]                     wdata_i,
    input  logic [rs5_pkg::REG_ADDR_W-1:0]  dbg_addr_i,
    output logic [31:0]                     dbg_data_o
);

    logic [rs5_pkg::XLEN-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;   // Every architectural register starts at zero
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i];   // x0 always reads zero

    // Retire drops rd == 0 before the write port, so a write to x0 means a broken pipe
    assert property (@(posedge clk) disable iff (!arst_n_i) we_i |-> (waddr_i != '0));

endmodule

`default_nettype wire

/* logic/retire.sv */
// Retire stage that aligns and extends load data and chooses what gets written back
`default_nettype none
`timescale 1ns/100ps

module retire (
    stage_if.sink                           wb,
    input  logic [31:0]                     mem_data_i,
    output logic                            regbank_we_o,
    output logic [rs5_pkg::REG_ADDR_W-1:0]  regbank_addr_o,
    output logic [31:0]                     regbank_data_o
);

    logic [7:0]   lane_byte;   // Byte chosen by result[1:0]
    logic [15:0]  lane_half;   // Halfword chosen by result[1]
    logic [31:0]  load_data;   // Aligned and extended memory value
    logic         is_load;
    logic         is_store;

    // Pull the addressed lane down to bit 0
    always_comb begin
        case (wb.op.result[1:0])
            2'b00:   lane_byte = mem_data_i[7:0];
            2'b01:   lane_byte = mem_data_i[15:8];
            2'b10:   lane_byte = mem_data_i[23:16];
            default: lane_byte = mem_data_i[31:24];
        endcase
        lane_half = wb.op.result[1] ? mem_data_i[31:16] : mem_data_i[15:0];
    end

    // Sign extension copies the top bit of the lane and the unsigned forms fill with zeros
    always_comb begin
        unique case (wb.op.operation)
            rs5_pkg::LB:  load_data = {{24{lane_byte[7]}}, lane_byte};
            rs5_pkg::LBU: load_data = {24'b0, lane_byte};
            rs5_pkg::LH:  load_data = {{16{lane_half[15]}}, lane_half};
            rs5_pkg::LHU: load_data = {16'b0, lane_half};
            default:      load_data = mem_data_i;   // LW takes the whole word
        endcase
    end

    always_comb begin
        unique case (wb.op.operation)
            rs5_pkg::LB, rs5_pkg::LBU, rs5_pkg::LH, rs5_pkg::LHU, rs5_pkg::LW: begin
                is_load  = 1'b1;
                is_store = 1'b0;
            end
            rs5_pkg::SB, rs5_pkg::SH, rs5_pkg::SW: begin
                is_load  = 1'b0;
                is_store = 1'b1;
            end
            default: begin   // ALU
                is_load  = 1'b0;
                is_store = 1'b0;
            end
        endcase
    end

    assign regbank_data_o = is_load ? load_data : wb.op.result;   // Memory value or execute result
    assign regbank_addr_o = wb.op.rd;

    // Stores finished in the memory stage, and x0 is filtered here so the bank never sees it
    assign regbank_we_o = wb.valid && !is_store && (wb.op.rd != '0);

endmodule

`default_nettype wire

/* logic/retire_backend.sv */
// Back end top that links the credit queue, memory stage, data RAM, retire and register bank
`default_nettype none
`timescale 1ns/100ps

module retire_backend (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            op_valid_i,
    input  rs5_pkg::iType_e                 op_operation_i,
    input  logic [rs5_pkg::REG_ADDR_W-1:0]  op_rd_i,
    input  logic [rs5_pkg::XLEN-1:0]        op_result_i,
    input  logic [rs5_pkg::XLEN-1:0]        op_store_data_i,
    output logic                            credit_o,
    input  logic [rs5_pkg::REG_ADDR_W-1:0]  dbg_addr_i,
    output logic [rs5_pkg::XLEN-1:0]        dbg_data_o
);

    rs5_pkg::op_t                       op_in;         // Packed form of the external fields
    logic [rs5_pkg::DMEM_ADDR_W-1:0]    dmem_addr;
    logic [3:0]                         dmem_be;
    logic [31:0]                        dmem_wdata;
    logic [31:0]                        dmem_rdata;
    logic                               rb_we;
    logic [rs5_pkg::REG_ADDR_W-1:0]     rb_addr;
    logic [31:0]                        rb_data;

    stage_if q2mem ();     // Queue head toward the memory stage
    stage_if mem2ret ();   // Memory stage toward retire

    assign op_in.operation  = op_operation_i;
    assign op_in.rd         = op_rd_i;
    assign op_in.result     = op_result_i;
    assign op_in.store_data = op_store_data_i;

    credit_fifo u_credit_fifo (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .op_valid_i (op_valid_i),
        .op_i       (op_in),
        .credit_o   (credit_o),
        .deq        (q2mem.source)
    );

    mem_stage u_mem_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .enq          (q2mem.sink),
        .ret          (mem2ret.source),
        .dmem_addr_o  (dmem_addr),
        .dmem_be_o    (dmem_be),
        .dmem_wdata_o (dmem_wdata)
    );

    data_memory u_data_memory (
        .clk     (clk),
        .addr_i  (dmem_addr),
        .be_i    (dmem_be),
        .wdata_i (dmem_wdata),
        .rdata_o (dmem_rdata)
    );

    retire u_retire (
        .wb             (mem2ret.sink),
        .mem_data_i     (dmem_rdata),   // Arrives together with mem2ret valid
        .regbank_we_o   (rb_we),
        .regbank_addr_o (rb_addr),
        .regbank_data_o (rb_data)
    );

    regbank u_regbank (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .we_i       (rb_we),
        .waddr_i    (rb_addr),
        .wdata_i    (rb_data),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o)
    );

endmodule

`default_nettype wire

/* logic/rs5_pkg.sv */
// RS5 back end package with operation codes, the operation payload and sizing constants
`default_nettype none

package rs5_pkg;

    localparam int XLEN        = 32;                       // Data path width
    localparam int REG_ADDR_W  = 5;                        // Selects one of 32 registers
    localparam int FIFO_DEPTH  = 4;                        // Queue slots, also the sender's credits
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);       // Read and write pointer width
    localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);   // Occupancy counter must reach FIFO_DEPTH
    localparam int DMEM_WORDS  = 256;                      // Data memory size in 32-bit words
    localparam int DMEM_ADDR_W = 8;                        // Word address taken from result[9:2]

    // Operation codes that reach the back end after execute
    typedef enum logic [3:0] {
        LB,     // Load byte, sign-extended
        LBU,    // Load byte, zero-extended
        LH,     // Load halfword, sign-extended
        LHU,    // Load halfword, zero-extended
        LW,     // Load word
        SB,     // Store byte
        SH,     // Store halfword
        SW,     // Store word
        ALU     // Register write of the execute result
    } iType_e;

    // One completed operation, 73 bits wide
    typedef struct packed {
        iType_e                 operation;   // What to do with the result
        logic [REG_ADDR_W-1:0]  rd;          // Destination register
        logic [XLEN-1:0]        result;      // Execute result or effective address
        logic [XLEN-1:0]        store_data;  // Data for stores, unused otherwise
    } op_t;

endpackage

`default_nettype wire

/* logic/stage_if.sv */
// Pipeline link that moves one operation per cycle from one back end block to the next
`default_nettype none
`timescale 1ns/100ps

interface stage_if;

    logic          valid;   // Op holds a live operation this cycle
    rs5_pkg::op_t  op;      // Operation payload

    // Upstream block drives the link
    modport source (
        output valid,
        output op
    );

    // Downstream block takes every operation it sees, so no ready exists
    modport sink (
        input valid,
        input op
    );

endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run from the project root, the log search decides the result
verilator --binary -Wno-fatal -f build.f --top-module tb_retire_backend -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && ! grep -q "sim failed" sim.log \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

/* tests/retire_stimulus.txt */
# S <code hex> <rd dec> <result hex> <store_data hex>, codes 0 LB 1 LBU 2 LH 3 LHU 4 LW 5 SB 6 SH 7 SW 8 ALU
# C <register dec> <expected value hex>, read through the debug port after all credits return
S 8 1 12345678 00000000
S 8 0 deadbeef 00000000
S 7 0 00000100 80f17f02
S 4 2 00000100 00000000
S 0 3 00000100 00000000
S 0 4 00000101 00000000
S 0 5 00000102 00000000
S 0 6 00000103 00000000
S 1 7 00000100 00000000
S 1 8 00000101 00000000
S 1 9 00000102 00000000
S 1 10 00000103 00000000
S 2 11 00000100 00000000
S 2 12 00000102 00000000
S 3 13 00000100 00000000
S 3 14 00000102 00000000
S 7 0 00000108 7ee18123
S 2 18 00000108 00000000
S 3 19 00000108 00000000
S 7 0 00000204 11223344
S 5 0 00000205 000000aa
S 6 0 00000206 0000beef
S 4 15 00000204 00000000
S 5 0 00000207 ffffff5a
S 4 16 00000204 00000000
S 8 17 cafef00d 00000000
C 0 00000000
C 1 12345678
C 2 80f17f02
C 3 00000002
C 4 0000007f
C 5 fffffff1
C 6 ffffff80
C 7 00000002
C 8 0000007f
C 9 000000f1
C 10 00000080
C 11 00007f02
C 12 ffff80f1
C 13 00007f02
C 14 000080f1
C 15 beefaa44
C 16 5aefaa44
C 17 cafef00d
C 18 ffff8123
C 19 00008123
C 20 00000000

/* tests/tb_retire_backend.sv */
// Testbench for the retire back end that replays file stimulus under credit control
`default_nettype none
`timescale 1ns/100ps

module tb_retire_backend;

    localparam int WAIT_LIMIT = 40;   // Longest any single wait may run, in cycles

    logic                   clk;
    logic                   arst_n_i;
    logic                   op_valid_i;
    rs5_pkg::iType_e        op_operation_i;
    logic [4:0]             op_rd_i;
    logic [31:0]            op_result_i;
    logic [31:0]            op_store_data_i;
    logic                   credit_o;
    logic [4:0]             dbg_addr_i;
    logic [31:0]            dbg_data_o;

    rs5_pkg::iType_e  send_code [$];     // Operations in file order
    logic [4:0]       send_rd [$];
    logic [31:0]      send_result [$];
    logic [31:0]      send_data [$];
    logic [4:0]       chk_reg [$];       // Registers to read back at the end
    logic [31:0]      chk_val [$];

    int  credits;                        // Sender's view of free queue slots
    bit  tracking;                       // Credit monitor runs once reset is over
    int  value_errors;
    int  credit_errors;

    retire_backend dut_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .op_valid_i      (op_valid_i),
        .op_operation_i  (op_operation_i),
        .op_rd_i         (op_rd_i),
        .op_result_i     (op_result_i),
        .op_store_data_i (op_store_data_i),
        .credit_o        (credit_o),
        .dbg_addr_i      (dbg_addr_i),
        .dbg_data_o      (dbg_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped at %0t: %s", $time, why);
        $display("sim failed");
        $finish;
    endtask

    // Loads never wait behind an idle cycle, so they follow their store closely
    function automatic int idle_before(input rs5_pkg::iType_e code);
        if (code <= rs5_pkg::LW) return 0;
        return int'($urandom % 3);
    endfunction

    // S lines are operations to send, C lines are register values expected at the end
    task automatic load_stimulus();
        int          fd;
        int          n;
        int          code;
        int          rd;
        logic [31:0] a;
        logic [31:0] b;
        string       line;
        fd = $fopen("tests/retire_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("the stimulus file tests/retire_stimulus.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] == "S") begin
                    n = $sscanf(line, "S %h %d %h %h", code, rd, a, b);
                    send_code.push_back(rs5_pkg::iType_e'(code));
                    send_rd.push_back(5'(rd));
                    send_result.push_back(a);
                    send_data.push_back(b);
                end else if (n > 0 && line[0] == "C") begin
                    n = $sscanf(line, "C %d %h", rd, a);
                    chk_reg.push_back(5'(rd));
                    chk_val.push_back(a);
                end
            end
            $fclose(fd);
        end
    endtask

    // Each cycle with credit_o high hands one slot back to the sender
    always @(negedge clk) begin
        if (tracking) begin
            if (credit_o) credits++;
            if (credits > rs5_pkg::FIFO_DEPTH) begin
                credit_errors++;
                $display("ERROR at %0t: the sender holds %0d credits, more than the queue depth",
                         $time, credits);
            end else if (credits < 0) begin
                credit_errors++;
                $display("ERROR at %0t: the sender's credit count went negative", $time);
            end
        end
    end

    initial begin
        int idx;
        int gap;
        int wait_cnt;
        void'($urandom(32'h4ebf));   // Single seed for the whole run
        arst_n_i        = 1'b0;
        op_valid_i      = 1'b0;
        op_operation_i  = rs5_pkg::ALU;
        op_rd_i         = '0;
        op_result_i     = '0;
        op_store_data_i = '0;
        dbg_addr_i      = '0;
        credits         = rs5_pkg::FIFO_DEPTH;
        tracking        = 1'b0;
        value_errors    = 0;
        credit_errors   = 0;
        load_stimulus();

        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_value("credit_o", {31'b0, credit_o}, 32'h0);   // Quiet while in reset
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_value("credit_o", {31'b0, credit_o}, 32'h0);   // Still quiet with an empty queue
        tracking = 1'b1;

        idx      = 0;
        gap      = 0;
        wait_cnt = 0;
        while (idx < send_code.size()) begin
            @(posedge clk);
            if (gap == 0 && credits > 0) begin
                op_valid_i      <= 1'b1;
                op_operation_i  <= send_code[idx];
                op_rd_i         <= send_rd[idx];
                op_result_i     <= send_result[idx];
                op_store_data_i <= send_data[idx];
                credits--;   // Spent as the operation goes out
                idx++;
                wait_cnt = 0;
                if (idx < send_code.size()) gap = idle_before(send_code[idx]);
            end else begin
                op_valid_i <= 1'b0;
                if (gap > 0) begin
                    gap--;
                end else begin
                    wait_cnt++;
                    if (wait_cnt > WAIT_LIMIT) begin
                        abort_run("no credit came back while operations were waiting to be sent");
                    end
                end
            end
        end
        @(posedge clk);
        op_valid_i <= 1'b0;

        wait_cnt = 0;
        while (credits != rs5_pkg::FIFO_DEPTH) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
                abort_run("not all credits returned after the last operation was sent");
            end
        end
        repeat (4) @(posedge clk);   // Last popped operation reaches the register bank

        foreach (chk_reg[k]) begin
            @(posedge clk);
            dbg_addr_i <= chk_reg[k];
            @(negedge clk);
            check_value($sformatf("dbg_data_o (x%0d)", chk_reg[k]), dbg_data_o, chk_val[k]);
        end

        $display("Checks done: %0d value errors, %0d credit errors", value_errors, credit_errors);
        if (value_errors + credit_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
